// ==== hw/kop_pkg.sv ====
// Word widths and beat structs; frames must be a multiple of four 64-bit words, eof on the last.
package kop_pkg;

   // Input word width in bits.
   localparam int kop_word_w = 64;

   // Fold block and digest width in bits.
   localparam int kop_block_w = 256;

   // One input word with its end-of-frame flag.
   typedef struct packed {
      logic                  eof;   // Last word of frame.
      logic [kop_word_w-1:0] data;
   } kop_beat64_t;

   // Two words after the first upsizer.
   typedef struct packed {
      logic                    eof;   // Taken from the second word of the pair.
      logic [2*kop_word_w-1:0] data;  // Older word in the upper half.
   } kop_beat128_t;

   // Four words, one fold block.
   typedef struct packed {
      logic                   eof;
      logic [kop_block_w-1:0] data;
   } kop_beat256_t;

   // Frame digest presented at frame end.
   typedef struct packed {
      logic [kop_block_w-1:0] data;  // XOR of all blocks of the frame.
   } kop_digest_t;

endpackage

// ==== hw/kop_upsizer_x2.sv ====
// Output data must be twice the input data width; a pair is only emitted on the second word.
`timescale 1ns/100ps

module kop_upsizer_x2 #(
   parameter type beat_in_t  = kop_pkg::kop_beat64_t,
   parameter type beat_out_t = kop_pkg::kop_beat128_t
) (
   input  logic      clk,
   input  logic      rst_n,

   // Narrow side.
   input  logic      in_valid,
   input  beat_in_t  in_beat,
   output logic      in_stall,

   // Wide side.
   output logic      out_valid,
   output beat_out_t out_beat,
   input  logic      out_stall
);

   logic     xfer;        // A word moves this cycle.
   logic     phase;       // High while the first word of a pair is held.
   beat_in_t first_beat;  // Buffered first word.

   // Back-pressure goes straight through, no skid.
   assign in_stall = out_stall;

   // Only a valid, unstalled word may touch the buffer or phase.
   assign xfer = in_valid && !out_stall;

   // Phase flips once per transferred word.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         phase <= 1'b0;
      end else if (xfer) begin
         phase <= ~phase;
      end
   end

   // First word of a pair is kept until its partner shows up.
   always_ff @(posedge clk) begin
      if (xfer && !phase) begin
         first_beat <= in_beat;
      end
   end

   // Pair completes in the same cycle the second word arrives.
   assign out_valid = xfer && phase;

   always_comb begin
      out_beat      = '0;
      out_beat.eof  = in_beat.eof;                      // Frame end follows the later word.
      out_beat.data = {first_beat.data, in_beat.data};  // Older word on top.
   end

endmodule

// ==== hw/kop_block_fold.sv ====
// Frames must end on a full 256-bit block; one digest is held at a time until taken.
`timescale 1ns/100ps

module kop_block_fold (
   input  logic                  clk,
   input  logic                  rst_n,

   // Block stream from the upsizers.
   input  logic                  in_valid,
   input  kop_pkg::kop_beat256_t in_beat,
   output logic                  in_stall,

   // Digest stream.
   output logic                  digest_valid,
   output kop_pkg::kop_digest_t  digest,
   input  logic                  digest_stall
);

   logic                           accept;  // Block enters the fold.
   logic                           take;    // Digest leaves this cycle.
   logic                           last;    // Accepted block closes its frame.
   logic [kop_pkg::kop_block_w-1:0] acc;     // Running XOR of the current frame.
   logic [kop_pkg::kop_block_w-1:0] folded;

   // Only a blocked digest holds up the input.
   assign in_stall = digest_valid && digest_stall;

   assign accept = in_valid && !in_stall;
   assign take   = digest_valid && !digest_stall;
   assign last   = accept && in_beat.eof;

   assign folded = acc ^ in_beat.data;

   // Accumulator restarts from zero after every frame.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         acc <= '0;
      end else if (accept) begin
         if (in_beat.eof) begin
            acc <= '0;
         end else begin
            acc <= folded;
         end
      end
   end

   // A new frame end may replace a digest that is being taken in the same cycle.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         digest_valid <= 1'b0;
      end else if (last) begin
         digest_valid <= 1'b1;
      end else if (take) begin
         digest_valid <= 1'b0;  // Consumed, nothing new behind it.
      end
   end

   // Held untouched while stalled, since last needs an unstalled input.
   always_ff @(posedge clk) begin
      if (last) begin
         digest.data <= folded;
      end
   end

endmodule

// ==== hw/kop_fold_top.sv ====
// Input words pair MSB-first into 256-bit blocks; stall reaches the source only via digest_stall.
`timescale 1ns/100ps

module kop_fold_top (
   input  logic                 clk,
   input  logic                 rst_n,

   // 64-bit word stream.
   input  logic                 in_valid,
   input  kop_pkg::kop_beat64_t in_beat,
   output logic                 in_stall,

   // Frame digest.
   output logic                 digest_valid,
   output kop_pkg::kop_digest_t digest,
   input  logic                 digest_stall
);

   // Link a, 128-bit pairs.
   logic                  link_a_valid;
   kop_pkg::kop_beat128_t link_a_beat;
   logic                  link_a_stall;

   // Link b, 256-bit blocks.
   logic                  link_b_valid;
   kop_pkg::kop_beat256_t link_b_beat;
   logic                  link_b_stall;

   // 64 to 128.
   kop_upsizer_x2 #(
      .beat_in_t  (kop_pkg::kop_beat64_t),
      .beat_out_t (kop_pkg::kop_beat128_t)
   ) u64 (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_beat   (in_beat),
      .in_stall  (in_stall),
      .out_valid (link_a_valid),
      .out_beat  (link_a_beat),
      .out_stall (link_a_stall)
   );

   // 128 to 256.
   kop_upsizer_x2 #(
      .beat_in_t  (kop_pkg::kop_beat128_t),
      .beat_out_t (kop_pkg::kop_beat256_t)
   ) u128 (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (link_a_valid),
      .in_beat   (link_a_beat),
      .in_stall  (link_a_stall),
      .out_valid (link_b_valid),
      .out_beat  (link_b_beat),
      .out_stall (link_b_stall)
   );

   // XOR fold and digest hold.
   kop_block_fold fold0 (
      .clk          (clk),
      .rst_n        (rst_n),
      .in_valid     (link_b_valid),
      .in_beat      (link_b_beat),
      .in_stall     (link_b_stall),
      .digest_valid (digest_valid),
      .digest       (digest),
      .digest_stall (digest_stall)
   );

endmodule

// ==== testbench/kop_fold_chk.sv ====
// Bound to kop_fold_top; assumes frames of whole 256-bit blocks with eof only on the last word.
`timescale 1ns/100ps

module kop_fold_chk (
   input logic                 clk,
   input logic                 rst_n,
   input logic                 in_valid,
   input kop_pkg::kop_beat64_t in_beat,
   input logic                 in_stall,
   input logic                 digest_valid,
   input kop_pkg::kop_digest_t digest,
   input logic                 digest_stall
);

   int unsigned fail_count = 0;  // Failed assertions so far.

   // Nothing pending right out of reset.
   reset_quiet: assert property (@(posedge clk) $rose(rst_n) |-> !digest_valid && !in_stall)
      else begin
         $error("digest_valid or in_stall high right after reset");
         fail_count++;
      end

   // Input stall only comes from a blocked digest.
   stall_source: assert property (@(posedge clk) disable iff (!rst_n)
      in_stall |-> digest_valid && digest_stall)
      else begin
         $error("in_stall high without a stalled digest");
         fail_count++;
      end

   // Held digest does not move under stall.
   digest_hold: assert property (@(posedge clk) disable iff (!rst_n)
      digest_valid && digest_stall |=> digest_valid && $stable(digest))
      else begin
         $error("digest changed or dropped while stalled");
         fail_count++;
      end

   // Frame end shows up one clock later.
   digest_latency: assert property (@(posedge clk) disable iff (!rst_n)
      !digest_valid && in_valid && !in_stall && in_beat.eof |=> digest_valid)
      else begin
         $error("digest_valid missing one cycle after the eof word");
         fail_count++;
      end

endmodule

// ==== testbench/kop_fold_tb.sv ====
// Frames are 4, 8 or 12 words with eof on the last; results repeat only with the fixed seed.
`timescale 1ns/100ps

module kop_fold_tb;

   logic                 clk;
   logic                 rst_n;
   logic                 in_valid;
   kop_pkg::kop_beat64_t in_beat;
   logic                 in_stall;
   logic                 digest_valid;
   kop_pkg::kop_digest_t digest;
   logic                 digest_stall;

   kop_pkg::kop_digest_t exp_q[$];  // Expected digests, oldest first.
   int                   digests_taken;
   bit                   stall_en;        // Random digest_stall.
   bit                   gap_en;          // Random idle cycles between words.

   kop_fold_top dut0 (
      .clk          (clk),
      .rst_n        (rst_n),
      .in_valid     (in_valid),
      .in_beat      (in_beat),
      .in_stall     (in_stall),
      .digest_valid (digest_valid),
      .digest       (digest),
      .digest_stall (digest_stall)
   );

   bind kop_fold_top kop_fold_chk chk0 (
      .clk          (clk),
      .rst_n        (rst_n),
      .in_valid     (in_valid),
      .in_beat      (in_beat),
      .in_stall     (in_stall),
      .digest_valid (digest_valid),
      .digest       (digest),
      .digest_stall (digest_stall)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;  // 4 ns period.
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TESTS FAILED");
      $fatal(1, "Simulation stopped at the first error.");
   endtask

   task automatic check_digest(input kop_pkg::kop_digest_t got,
                               input kop_pkg::kop_digest_t exp,
                               input int                   frame_no);
      if (got !== exp) begin
         abort_run($sformatf("[ERROR] %0t: frame %0d digest %h, expected %h",
                             $time, frame_no, got.data, exp.data));
      end
   endtask

   // Reference fold. Four words per block, first word in the top 64 bits.
   function automatic kop_pkg::kop_digest_t model_fold(
      input logic [kop_pkg::kop_word_w-1:0] words[12],
      input int                             n);
      kop_pkg::kop_digest_t                d;
      logic [kop_pkg::kop_block_w-1:0]     block;
      d.data = '0;
      block  = '0;
      for (int i = 0; i < n; i++) begin
         block = {block[kop_pkg::kop_block_w-kop_pkg::kop_word_w-1:0], words[i]};
         if (i % 4 == 3) begin
            d.data ^= block;  // Block complete.
         end
      end
      return d;
   endfunction

   task automatic drive_digest_stall();
      forever begin
         @(posedge clk);
         #1;
         if (stall_en) begin
            digest_stall = ($urandom_range(99, 0) < 40);
         end else begin
            digest_stall = 1'b0;
         end
      end
   endtask

   // Valid low with junk on the beat.
   task automatic idle_cycles(input int n);
      in_valid     = 1'b0;
      in_beat.eof  = 1'b1;
      in_beat.data = {$urandom, $urandom};
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   // Entered 1 ns after an edge, returns 1 ns after the edge that took the word.
   task automatic send_word(input kop_pkg::kop_beat64_t beat);
      int waited;
      bit taken;
      waited   = 0;
      taken    = 1'b0;
      in_valid = 1'b1;
      in_beat  = beat;
      while (!taken) begin
         #2;
         taken = !in_stall;  // Settled one ns before the edge.
         @(posedge clk);
         #1;
         waited++;
         if (!taken && waited > 200) begin
            abort_run("Timeout: in_stall stayed high for 200 cycles, a word was never accepted.");
         end
      end
      in_valid = 1'b0;
   endtask

   task automatic send_frame(input int blocks);
      logic [kop_pkg::kop_word_w-1:0] words[12];
      kop_pkg::kop_beat64_t           beat;
      int                             n;
      n = 4 * blocks;
      for (int i = 0; i < 12; i++) begin
         words[i] = {$urandom, $urandom};
      end
      exp_q.push_back(model_fold(words, n));
      for (int i = 0; i < n; i++) begin
         beat.eof  = (i == n - 1);
         beat.data = words[i];
         send_word(beat);
         if (gap_en && $urandom_range(2, 0) == 0) begin
            idle_cycles($urandom_range(3, 1));
         end
      end
   endtask

   task automatic wait_for_drain();
      int waited;
      waited = 0;
      while (exp_q.size() != 0) begin
         @(posedge clk);
         #2;
         waited++;
         if (waited > 500) begin
            abort_run($sformatf("Timeout: %0d digests never arrived.", exp_q.size()));
         end
      end
   endtask

   task automatic check_quiet();
      repeat (50) begin
         @(posedge clk);
         #2;
         if (digest_valid) begin
            abort_run("An extra digest_valid appeared after the last frame was taken.");
         end
      end
   endtask

   // Takes digests as they leave and checks them in frame order.
   initial begin : digest_monitor
      forever begin
         @(posedge clk);
         #3;
         if (dut0.chk0.fail_count != 0) begin
            abort_run("A bound assertion on kop_fold_top failed.");
         end
         if (rst_n && digest_valid && !digest_stall) begin
            if (exp_q.size() == 0) begin
               abort_run($sformatf("[ERROR] %0t: digest taken with no frame outstanding",
                                   $time));
            end
            check_digest(digest, exp_q.pop_front(), digests_taken);
            digests_taken++;
         end
      end
   end

   initial begin : main_seq
      void'($urandom(32'h304a8da2));
      rst_n         = 1'b0;
      in_valid      = 1'b0;
      in_beat       = '0;
      digest_stall  = 1'b0;
      stall_en      = 1'b0;
      gap_en        = 1'b0;
      digests_taken = 0;
      repeat (10) @(posedge clk);
      #1;
      rst_n = 1'b1;
      fork
         drive_digest_stall();  // Inherits the seeded generator.
      join_none

      // Single-block frames, back to back.
      repeat (4) send_frame(1);

      // Multi-block frames, accumulator must clear between them.
      repeat (6) send_frame($urandom_range(3, 2));

      // Random digest back-pressure.
      stall_en = 1'b1;
      repeat (12) send_frame($urandom_range(3, 1));

      // Idle gaps inside pairs and between pairs.
      stall_en = 1'b0;
      gap_en   = 1'b1;
      repeat (12) send_frame($urandom_range(3, 1));

      // Everything at once.
      stall_en = 1'b1;
      repeat (30) send_frame($urandom_range(3, 1));

      wait_for_drain();
      stall_en = 1'b0;
      check_quiet();

      if (dut0.chk0.fail_count == 0) begin
         $display("TESTS PASSED");
         $finish;
      end else begin
         abort_run("A bound assertion on kop_fold_top failed in the last cycles of the run.");
      end
   end

endmodule

// ==== verilog.f ====
hw/kop_pkg.sv
hw/kop_upsizer_x2.sv
hw/kop_block_fold.sv
hw/kop_fold_top.sv
testbench/kop_fold_chk.sv
testbench/kop_fold_tb.sv
